// ==== src/dot_engine_defs.svh ====
`ifndef DOT_ENGINE_DEFS_SVH
`define DOT_ENGINE_DEFS_SVH

// lane count, power of two
`define DE_LANES 8

// operand widths
`define DE_ACT_W 8
`define DE_WGT_W 8

// product width plus one bit per adder level
`define DE_SUM_W 19

`endif

// ==== src/dot_engine_pkg.sv ====
`default_nettype none

`include "dot_engine_defs.svh"

package dot_engine_pkg;

	// unsigned operands
	typedef logic [`DE_ACT_W-1:0] act_t;
	typedef logic [`DE_WGT_W-1:0] wgt_t;

	// full precision lane product
	typedef logic [`DE_ACT_W+`DE_WGT_W-1:0] prod_t;

	// reduction result, wraps past this width
	typedef logic [`DE_SUM_W-1:0] sum_t;

	// one select bit per lane, bit k is lane k
	typedef logic [`DE_LANES-1:0] mask_t;

	// weight address
	typedef logic [$clog2(`DE_LANES)-1:0] lane_idx_t;

	// item carried down the distribution tree
	typedef struct packed
	{
		act_t  act;
		mask_t mask;
	} dist_item_t;

endpackage

`default_nettype wire

// ==== src/dist_tree.sv ====
`default_nettype none

`include "dot_engine_defs.svh"

module dist_tree #(
	parameter int LANES = `DE_LANES,	// power of two
	parameter type payload_t = dot_engine_pkg::dist_item_t	// must carry a mask field
) (
	input wire CLK,
	input wire i_rst_n,
	input wire i_en,
	input wire i_valid,
	input wire payload_t i_data,
	output logic o_item,
	output logic [LANES-1:0] o_valid,
	output payload_t [LANES-1:0] o_data
);

	localparam int LEVELS = $clog2(LANES);

	// level 0 is the root register, level LEVELS the leaf registers
	for (genvar l = 0; l <= LEVELS; l++)
	begin : g_lvl
		localparam int NODES = 1 << l;

		payload_t [NODES-1:0] data_in;
		payload_t [NODES-1:0] data;
		logic [NODES-1:0] valid_in;
		logic [NODES-1:0] valid;
		logic item_in;
		logic item;

		if (l == 0)
		begin : g_root
			// root passes the item valid unpruned
			assign data_in[0] = i_data;
			assign valid_in[0] = i_valid;
			assign item_in = i_valid;
		end
		else
		begin : g_fan
			localparam int SPAN = LANES >> l;	// leaves below one node

			always_comb
			begin
				for (int k = 0; k < NODES; k++)
				begin
					data_in[k] = g_lvl[l-1].data[k/2];
					// child fires only if some lane below it is selected
					valid_in[k] = g_lvl[l-1].valid[k/2]
						& (|g_lvl[l-1].data[k/2].mask[k*SPAN +: SPAN]);
				end
			end

			assign item_in = g_lvl[l-1].item;
		end

		always_ff @(posedge CLK)
		begin
			if (!i_rst_n || !i_en)
			begin
				data <= '0;
				valid <= '0;
				item <= 1'b0;
			end
			else
			begin
				data <= data_in;	// broadcast, both children get a copy
				valid <= valid_in;
				item <= item_in;
			end
		end
	end

	assign o_item = g_lvl[LEVELS].item;
	assign o_valid = g_lvl[LEVELS].valid;
	assign o_data = g_lvl[LEVELS].data;

	// pruning may drop lanes but never invents an item
	a_leaf_has_item: assert property (
		@(posedge CLK) disable iff (!i_rst_n)
		(|o_valid) |-> o_item
	);

endmodule

`default_nettype wire

// ==== src/mult_lanes.sv ====
`default_nettype none

`include "dot_engine_defs.svh"

module mult_lanes #(
	parameter int LANES = `DE_LANES
) (
	input wire CLK,
	input wire i_rst_n,
	input wire i_en,
	input wire i_item,
	input wire [LANES-1:0] i_valid,
	input wire dot_engine_pkg::act_t [LANES-1:0] i_act,
	input wire i_w_load,
	input wire dot_engine_pkg::lane_idx_t i_w_idx,
	input wire dot_engine_pkg::wgt_t i_w_data,
	output logic o_item,
	output logic [LANES-1:0] o_valid,
	output dot_engine_pkg::prod_t [LANES-1:0] o_prod
);

	import dot_engine_pkg::*;

	wgt_t [LANES-1:0] weight;

	// stationary weights, enable does not touch them
	always_ff @(posedge CLK)
	begin
		if (!i_rst_n)
			weight <= '0;
		else if (i_w_load)
			weight[i_w_idx] <= i_w_data;
	end

	always_ff @(posedge CLK)
	begin
		if (!i_rst_n || !i_en)
		begin
			o_item <= 1'b0;
			o_valid <= '0;
			o_prod <= '0;
		end
		else
		begin
			o_item <= i_item;
			o_valid <= i_valid;
			for (int k = 0; k < LANES; k++)
			begin
				if (i_valid[k])
					o_prod[k] <= prod_t'(i_act[k]) * prod_t'(weight[k]);
				else
					o_prod[k] <= '0;	// idle lane adds nothing
			end
		end
	end

	// index port may be wider than the lane count needs
	a_w_idx_range: assert property (
		@(posedge CLK) disable iff (!i_rst_n)
		i_w_load |-> (int'(i_w_idx) < LANES)
	);

endmodule

`default_nettype wire

// ==== src/reduce_tree.sv ====
`default_nettype none

`include "dot_engine_defs.svh"

module reduce_tree #(
	parameter int LANES = `DE_LANES
) (
	input wire CLK,
	input wire i_rst_n,
	input wire i_en,
	input wire i_item,
	input wire [LANES-1:0] i_valid,
	input wire dot_engine_pkg::prod_t [LANES-1:0] i_prod,
	output logic o_valid,
	output dot_engine_pkg::sum_t o_sum,
	output dot_engine_pkg::prod_t [LANES-1:0] o_prod
);

	import dot_engine_pkg::*;

	localparam int LEVELS = $clog2(LANES);

	// each level halves the operand count
	for (genvar l = 1; l <= LEVELS; l++)
	begin : g_lvl
		localparam int NODES = LANES >> l;

		sum_t [2*NODES-1:0] opnd;
		sum_t [NODES-1:0] sum;
		prod_t [LANES-1:0] prod_in;
		prod_t [LANES-1:0] prod_d;	// travels with the sums
		logic item_in;
		logic item;

		if (l == 1)
		begin : g_leaf
			always_comb
			begin
				for (int k = 0; k < 2*NODES; k++)
					opnd[k] = i_valid[k] ? sum_t'(i_prod[k]) : '0;
			end

			assign prod_in = i_prod;
			// zero mask items still report through the item flag
			assign item_in = i_item | (|i_valid);
		end
		else
		begin : g_inner
			assign opnd = g_lvl[l-1].sum;
			assign prod_in = g_lvl[l-1].prod_d;
			assign item_in = g_lvl[l-1].item;
		end

		always_ff @(posedge CLK)
		begin
			if (!i_rst_n || !i_en)
			begin
				sum <= '0;
				prod_d <= '0;
				item <= 1'b0;
			end
			else
			begin
				for (int k = 0; k < NODES; k++)
					sum[k] <= opnd[2*k] + opnd[2*k+1];	// wraps to sum width
				prod_d <= prod_in;
				item <= item_in;
			end
		end
	end

	assign o_valid = g_lvl[LEVELS].item;
	assign o_sum = g_lvl[LEVELS].sum[0];
	assign o_prod = g_lvl[LEVELS].prod_d;

	// a flush empties every level of this tree
	a_flush_quiet: assert property (
		@(posedge CLK) disable iff (!i_rst_n)
		!i_en |=> !o_valid [*LEVELS]
	);

endmodule

`default_nettype wire

// ==== src/dot_engine_top.sv ====
`default_nettype none

`include "dot_engine_defs.svh"

module dot_engine_top (
	input wire CLK,
	input wire i_rst_n,
	input wire i_en,
	input wire i_valid,
	input wire dot_engine_pkg::act_t i_act,
	input wire dot_engine_pkg::mask_t i_mask,
	input wire i_w_load,
	input wire dot_engine_pkg::lane_idx_t i_w_idx,
	input wire dot_engine_pkg::wgt_t i_w_data,
	output logic o_valid,
	output dot_engine_pkg::sum_t o_sum,
	output dot_engine_pkg::prod_t [`DE_LANES-1:0] o_prod
);

	import dot_engine_pkg::*;

	dist_item_t in_item;

	logic leaf_item;
	logic [`DE_LANES-1:0] leaf_valid;
	dist_item_t [`DE_LANES-1:0] leaf_data;
	act_t [`DE_LANES-1:0] leaf_act;

	logic mul_item;
	logic [`DE_LANES-1:0] mul_valid;
	prod_t [`DE_LANES-1:0] mul_prod;

	assign in_item.act = i_act;
	assign in_item.mask = i_mask;

	dist_tree #(
		.LANES(`DE_LANES),
		.payload_t(dist_item_t)
	) u_dist (
		.CLK(CLK),
		.i_rst_n(i_rst_n),
		.i_en(i_en),
		.i_valid(i_valid),
		.i_data(in_item),
		.o_item(leaf_item),
		.o_valid(leaf_valid),
		.o_data(leaf_data)
	);

	// lanes only need the activation, mask is spent in the tree
	always_comb
	begin
		for (int k = 0; k < `DE_LANES; k++)
			leaf_act[k] = leaf_data[k].act;
	end

	mult_lanes #(
		.LANES(`DE_LANES)
	) u_mult (
		.CLK(CLK),
		.i_rst_n(i_rst_n),
		.i_en(i_en),
		.i_item(leaf_item),
		.i_valid(leaf_valid),
		.i_act(leaf_act),
		.i_w_load(i_w_load),
		.i_w_idx(i_w_idx),
		.i_w_data(i_w_data),
		.o_item(mul_item),
		.o_valid(mul_valid),
		.o_prod(mul_prod)
	);

	reduce_tree #(
		.LANES(`DE_LANES)
	) u_reduce (
		.CLK(CLK),
		.i_rst_n(i_rst_n),
		.i_en(i_en),
		.i_item(mul_item),
		.i_valid(mul_valid),
		.i_prod(mul_prod),
		.o_valid(o_valid),
		.o_sum(o_sum),
		.o_prod(o_prod)	// delay matched copy
	);

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD = 40,	// ns
	parameter int RST_CYCLES = 3
) (
	output logic o_clk,
	output logic o_rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		o_clk = 1'b0;
		forever
			#(PERIOD / 2) o_clk = ~o_clk;
	end

	// released on a falling edge, away from the sampling edge
	initial
	begin
		o_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb/dot_checker.sv ====
`default_nettype none

`include "dot_engine_defs.svh"

module dot_checker (
	input wire CLK,
	input wire i_rst_n,
	input wire i_en,
	input wire i_valid,
	input wire dot_engine_pkg::sum_t i_exp_sum,
	input wire dot_engine_pkg::prod_t [`DE_LANES-1:0] i_exp_prod,
	input wire i_dut_valid,
	input wire dot_engine_pkg::sum_t i_dut_sum,
	input wire dot_engine_pkg::prod_t [`DE_LANES-1:0] i_dut_prod,
	input int i_test_id,
	input int i_timeouts,
	input wire i_done,
	output int o_pending,
	output int o_errors,
	output logic o_reported
);
	timeunit 1ns;
	timeprecision 1ps;

	import dot_engine_pkg::*;

	localparam int LATENCY = 8;	// strobe to o_valid

	typedef struct
	{
		int stamp;
		int test_id;
		sum_t sum;
		prod_t [`DE_LANES-1:0] prod;
	} exp_t;

	exp_t exp_q[$];
	int cycle;
	int checked;
	int dropped;
	int errors;
	logic live;

	function automatic string test_name(input int id);
		case (id)
			0: return "reset";
			1: return "latency";
			2: return "masking";
			3: return "streaming";
			4: return "flush";
			5: return "wide";
			default: return "unknown";
		endcase
	endfunction

	// inputs are stable at the rising edge
	task automatic take_inputs();
		exp_t e;
		if (!i_rst_n)
			exp_q.delete();
		else if (!i_en)
		begin
			// every item in flight is lost, the one at the door too
			dropped += exp_q.size() + (i_valid ? 1 : 0);
			exp_q.delete();
		end
		else if (i_valid)
		begin
			e.stamp = cycle;
			e.test_id = i_test_id;
			e.sum = i_exp_sum;
			e.prod = i_exp_prod;
			exp_q.push_back(e);
		end
	endtask

	task automatic compare_outputs();
		exp_t e;
		string name;
		int now;
		now = cycle + 1;	// this cycle ends at the next rising edge
		if (!i_dut_valid)
		begin
			if (i_dut_sum !== '0 || i_dut_prod !== '0)
			begin
				errors++;
				$write("** Error [%s] idle output: expected sum 0 products 0, ",
					test_name(i_test_id));
				$display("actual sum %0d products %h", i_dut_sum, i_dut_prod);
			end
			if (exp_q.size() > 0 && now > exp_q[0].stamp + LATENCY)
			begin
				errors++;
				$display("result of the item sent in cycle %0d never arrived",
					exp_q[0].stamp);
				void'(exp_q.pop_front());
			end
			return;
		end
		if (exp_q.size() == 0)
		begin
			errors++;
			$display("o_valid in cycle %0d while no item was outstanding", now);
			return;
		end
		e = exp_q.pop_front();
		name = test_name(e.test_id);
		checked++;
		if (now - e.stamp != LATENCY)
		begin
			errors++;
			$display("** Error [%s] latency: expected %0d, actual %0d",
				name, LATENCY, now - e.stamp);
		end
		if (i_dut_sum !== e.sum)
		begin
			errors++;
			$display("** Error [%s] sum: expected %0d, actual %0d", name, e.sum, i_dut_sum);
		end
		for (int k = 0; k < `DE_LANES; k++)
		begin
			if (i_dut_prod[k] !== e.prod[k])
			begin
				errors++;
				$display("** Error [%s] lane %0d product: expected %0d, actual %0d",
					name, k, e.prod[k], i_dut_prod[k]);
			end
		end
	endtask

	initial
	begin
		cycle = 0;
		checked = 0;
		dropped = 0;
		errors = 0;
		live = 1'b0;
		o_pending = 0;
		o_errors = 0;
		o_reported = 1'b0;
		forever
		begin
			@(posedge CLK);
			cycle++;
			live = i_rst_n;
			take_inputs();
			if (i_done && !o_reported)
			begin
				o_errors = errors;
				$display("checked %0d results, dropped by flush %0d, errors %0d, timeouts %0d",
					checked, dropped, errors, i_timeouts);
				o_reported = 1'b1;
			end
			@(negedge CLK);	// outputs settled here
			if (live)
				compare_outputs();
			o_pending = exp_q.size();
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_dot_engine.sv ====
`default_nettype none

`include "dot_engine_defs.svh"

module tb_dot_engine;
	timeunit 1ns;
	timeprecision 1ps;

	import dot_engine_pkg::*;

	localparam int TIMEOUT = 50;	// cycles per wait

	typedef struct packed
	{
		sum_t sum;
		prod_t [`DE_LANES-1:0] prod;
	} result_t;

	logic CLK;
	logic i_rst_n;
	logic i_en;
	logic i_valid;
	act_t i_act;
	mask_t i_mask;
	logic i_w_load;
	lane_idx_t i_w_idx;
	wgt_t i_w_data;
	logic o_valid;
	sum_t o_sum;
	prod_t [`DE_LANES-1:0] o_prod;

	result_t expected;
	wgt_t w_model [`DE_LANES];	// what the lanes should hold
	int seed;
	int test_id;
	int timeouts;
	logic done;
	int pending;
	int err_count;
	logic reported;

	tb_clk_gen u_clk (
		.o_clk(CLK),
		.o_rst_n(i_rst_n)
	);

	dot_engine_top u_dut (.*);

	dot_checker u_chk (
		.CLK(CLK),
		.i_rst_n(i_rst_n),
		.i_en(i_en),
		.i_valid(i_valid),
		.i_exp_sum(expected.sum),
		.i_exp_prod(expected.prod),
		.i_dut_valid(o_valid),
		.i_dut_sum(o_sum),
		.i_dut_prod(o_prod),
		.i_test_id(test_id),
		.i_timeouts(timeouts),
		.i_done(done),
		.o_pending(pending),
		.o_errors(err_count),
		.o_reported(reported)
	);

	// masked lanes give zero, the sum wraps at the sum width
	function automatic result_t ref_result(input act_t a, input mask_t m);
		result_t r;
		int acc;
		acc = 0;
		for (int k = 0; k < `DE_LANES; k++)
		begin
			r.prod[k] = m[k] ? prod_t'(int'(a) * int'(w_model[k])) : '0;
			acc += int'(r.prod[k]);
		end
		r.sum = sum_t'(acc % (1 << `DE_SUM_W));
		return r;
	endfunction

	task automatic send_item(input act_t a, input mask_t m);
		@(negedge CLK);
		i_w_load = 1'b0;
		i_valid = 1'b1;
		i_act = a;
		i_mask = m;
		expected = ref_result(a, m);
	endtask

	task automatic load_weight(input int idx, input wgt_t w);
		@(negedge CLK);
		i_valid = 1'b0;
		i_w_load = 1'b1;
		i_w_idx = lane_idx_t'(idx);
		i_w_data = w;
		w_model[idx] = w;
	endtask

	task automatic load_weights(input logic rand_w, input wgt_t w);
		for (int k = 0; k < `DE_LANES; k++)
			load_weight(k, rand_w ? wgt_t'($random(seed)) : w);
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(negedge CLK);
			i_valid = 1'b0;
			i_w_load = 1'b0;
		end
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (!i_rst_n && n < TIMEOUT)
		begin
			@(posedge CLK);
			n++;
		end
		if (!i_rst_n)
		begin
			timeouts++;
			$display("timeout: reset still asserted after %0d cycles", TIMEOUT);
		end
	endtask

	task automatic wait_drain();
		int n;
		idle(1);
		n = 0;
		@(posedge CLK);
		while (pending != 0 && n < TIMEOUT)
		begin
			@(posedge CLK);
			n++;
		end
		if (pending != 0)
		begin
			timeouts++;
			$display("timeout in test %0d: %0d results still outstanding after %0d cycles",
				test_id, pending, TIMEOUT);
		end
	endtask

	initial
	begin
		int n;
		seed = 24;
		i_en = 1'b1;
		i_valid = 1'b0;
		i_act = '0;
		i_mask = '0;
		i_w_load = 1'b0;
		i_w_idx = '0;
		i_w_data = '0;
		expected = '0;
		test_id = 0;
		timeouts = 0;
		done = 1'b0;
		for (int k = 0; k < `DE_LANES; k++)
			w_model[k] = '0;
		wait_reset();

		idle(20);	// reset state, outputs must stay quiet

		test_id = 1;
		load_weights(1'b1, '0);
		send_item(act_t'($random(seed)), '1);
		wait_drain();

		test_id = 2;
		for (int k = 0; k < `DE_LANES; k++)
			send_item(act_t'($random(seed)), mask_t'(1 << k));
		repeat (8) send_item(act_t'($random(seed)), mask_t'($random(seed)));
		send_item(act_t'($random(seed)), '0);
		wait_drain();

		test_id = 3;
		for (int b = 0; b < 4; b++)
		begin
			load_weights(1'b1, '0);	// only once the pipeline is empty
			repeat (50) send_item(act_t'($random(seed)), mask_t'($random(seed)));
			wait_drain();
		end

		test_id = 4;
		for (int i = 0; i < 20; i++)
		begin
			send_item(act_t'($random(seed)), mask_t'($random(seed)));
			i_en = (i != 10);	// one flush cycle mid stream
		end
		wait_drain();
		repeat (10) send_item(act_t'($random(seed)), mask_t'($random(seed)));
		wait_drain();

		test_id = 5;
		load_weights(1'b0, 8'hff);
		repeat (3) send_item(8'hff, '1);
		wait_drain();

		idle(1);
		done = 1'b1;
		n = 0;
		while (!reported && n < TIMEOUT)
		begin
			@(negedge CLK);
			n++;
		end
		if (!reported)
		begin
			$display("timeout: checker gave no final report");
			$display("TEST FAILED");
		end
		else if (err_count == 0 && timeouts == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dot_engine.f ====
+incdir+src
src/dot_engine_pkg.sv
src/dist_tree.sv
src/mult_lanes.sv
src/reduce_tree.sv
src/dot_engine_top.sv
tb/tb_clk_gen.sv
tb/dot_checker.sv
tb/tb_dot_engine.sv

// ==== Makefile ====
# Verilator build and run of the dot engine testbench

VERILATOR ?= verilator
TOP       ?= tb_dot_engine
FILELIST  ?= dot_engine.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TEST FAILED
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the simulation, write $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "override: VERILATOR TOP FILELIST BUILD_DIR LOG FAIL_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
